// ==== dv/cache_aq_tb.sv ====
module cache_aq_tb;

    localparam int DATA_W      = 32;
    localparam int DEPTH       = 8;
    localparam int ADDR_W      = cache_aq_pkg::ADDR_W;
    localparam int SIZE_W      = cache_aq_pkg::SIZE_W;
    localparam int ENTRY_W     = 3 + 2 * ADDR_W + 2 * SIZE_W + 4 * DATA_W;
    localparam int EXP_W       = 5 + ENTRY_W;      // Empty, bus/wb/rd/sw flags, entry
    localparam int RAND_CYCLES = 1400;
    localparam int MAX_CYCLES  = 2000;             // Reset, ~60 directed and random, plus margin

    logic              clk;
    logic              rst_i, flush_i, pop_i;
    logic              rd_push_i, rd_valid_e_i, rd_valid_o_i, rd_pcd_i;
    logic [ADDR_W-1:0] rd_addr_e_i, rd_addr_o_i;
    logic [SIZE_W-1:0] rd_size_e_i, rd_size_o_i;
    logic              sw_push_i, sw_valid_e_i, sw_valid_o_i, sw_pcd_i;
    logic [ADDR_W-1:0] sw_addr_e_i, sw_addr_o_i;
    logic [SIZE_W-1:0] sw_size_e_i, sw_size_o_i;
    logic              wb_push_i, wb_valid_e_i, wb_valid_o_i, wb_pcd_i;
    logic [ADDR_W-1:0] wb_addr_e_i, wb_addr_o_i;
    logic [SIZE_W-1:0] wb_size_e_i, wb_size_o_i;
    logic [DATA_W-1:0] wb_data_e_i, wb_data_o_i, wb_mask_e_i, wb_mask_o_i;
    logic              bus_pending_i, bus_valid_e_i, bus_valid_o_i, bus_pcd_i;
    logic [ADDR_W-1:0] bus_addr_e_i, bus_addr_o_i;
    logic [DATA_W-1:0] bus_data_e_i, bus_data_o_i;

    logic              valid_e_o, valid_o_o, pcd_o;
    logic [ADDR_W-1:0] addr_e_o, addr_o_o;
    logic [SIZE_W-1:0] size_e_o, size_o_o;
    logic [DATA_W-1:0] data_e_o, data_o_o, mask_e_o, mask_o_o;
    logic              src_rd_o, src_sw_o, src_wb_o, src_bus_o;
    logic              aq_empty_o, rd_full_o, sw_full_o, wb_full_o;

    logic [15:0]        lfsr_state;
    logic [ENTRY_W-1:0] rd_mdl[$];
    logic [ENTRY_W-1:0] sw_mdl[$];
    logic [ENTRY_W-1:0] wb_mdl[$];
    logic [EXP_W-1:0]   exp_word;
    logic [EXP_W-1:0]   got_word;
    logic [2:0]         exp_full;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;

    cache_aq_top #(.DATA_W(DATA_W), .DEPTH(DEPTH)) uut (.*);

    assign got_word = {aq_empty_o, src_bus_o, src_wb_o, src_rd_o, src_sw_o,
                       valid_e_o, valid_o_o, addr_e_o, addr_o_o, size_e_o, size_o_o,
                       data_e_o, data_o_o, mask_e_o, mask_o_o, pcd_o};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            r          = {r[30:0], b};
        end
        return r;
    endfunction

    // Expected presentation: bus first, then wb, rd, sw
    function automatic logic [EXP_W-1:0] expected_present();
        logic [3:0]         flags;
        logic [ENTRY_W-1:0] ent;
        flags = 4'b0000;
        ent   = '0;
        if (bus_pending_i) begin
            flags = 4'b1000;
            ent   = {bus_valid_e_i, bus_valid_o_i, bus_addr_e_i, bus_addr_o_i,
                     {2 * SIZE_W{1'b0}}, bus_data_e_i, bus_data_o_i,
                     {2 * DATA_W{1'b1}}, bus_pcd_i};           // Fill covers the whole line
        end else if (wb_mdl.size() > 0) begin
            flags = 4'b0100;
            ent   = wb_mdl[0];
        end else if (rd_mdl.size() > 0) begin
            flags = 4'b0010;
            ent   = rd_mdl[0];
        end else if (sw_mdl.size() > 0) begin
            flags = 4'b0001;
            ent   = sw_mdl[0];
        end
        return {flags == 4'b0000, flags, ent};
    endfunction

    // Next-edge update of the model queues
    task automatic update_model(input logic [3:0] flags);
        logic [ENTRY_W-1:0] junk;
        if (rst_i) begin
            rd_mdl.delete();
            sw_mdl.delete();
            wb_mdl.delete();
        end else begin
            if (pop_i && flags[2]) junk = wb_mdl.pop_front();
            if (pop_i && flags[1]) junk = rd_mdl.pop_front();
            if (pop_i && flags[0]) junk = sw_mdl.pop_front();
            if (wb_push_i && wb_mdl.size() < DEPTH) begin
                wb_mdl.push_back({wb_valid_e_i, wb_valid_o_i, wb_addr_e_i, wb_addr_o_i,
                                  wb_size_e_i, wb_size_o_i, wb_data_e_i, wb_data_o_i,
                                  wb_mask_e_i, wb_mask_o_i, wb_pcd_i});
            end
            if (flush_i) begin
                rd_mdl.delete();                               // Same-cycle pushes are lost
                sw_mdl.delete();
            end else begin
                if (rd_push_i && rd_mdl.size() < DEPTH) begin
                    rd_mdl.push_back({rd_valid_e_i, rd_valid_o_i, rd_addr_e_i, rd_addr_o_i,
                                      rd_size_e_i, rd_size_o_i, {4 * DATA_W{1'b0}}, rd_pcd_i});
                end
                if (sw_push_i && sw_mdl.size() < DEPTH) begin
                    sw_mdl.push_back({sw_valid_e_i, sw_valid_o_i, sw_addr_e_i, sw_addr_o_i,
                                      sw_size_e_i, sw_size_o_i, {4 * DATA_W{1'b0}}, sw_pcd_i});
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        exp_word = expected_present();
        exp_full = {rd_mdl.size() == DEPTH, sw_mdl.size() == DEPTH, wb_mdl.size() == DEPTH};
        if (!rst_i) begin
            checks++;
            assert (got_word[EXP_W-1 -: 7] == exp_word[EXP_W-1 -: 7]) else begin
                errors++;
                $display("mismatch at %0t: empty/flags/valids got %b expected %b",
                         $time, got_word[EXP_W-1 -: 7], exp_word[EXP_W-1 -: 7]);
            end
            if (!exp_word[EXP_W-1]) begin
                assert (got_word[ENTRY_W-1:0] == exp_word[ENTRY_W-1:0]) else begin
                    errors++;
                    $display("mismatch at %0t: entry got %h expected %h",
                             $time, got_word[ENTRY_W-1:0], exp_word[ENTRY_W-1:0]);
                end
            end
            assert ({rd_full_o, sw_full_o, wb_full_o} == exp_full) else begin
                errors++;
                $display("mismatch at %0t: full flags rd/sw/wb got %b expected %b",
                         $time, {rd_full_o, sw_full_o, wb_full_o}, exp_full);
            end
        end
        update_model(exp_word[ENTRY_W +: 4]);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles, stopped by timeout", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic randomize_fields();
        rd_valid_e_i  <= 1'(rand_bits(1));
        rd_valid_o_i  <= 1'(rand_bits(1));
        rd_addr_e_i   <= ADDR_W'(rand_bits(ADDR_W));
        rd_addr_o_i   <= ADDR_W'(rand_bits(ADDR_W));
        rd_size_e_i   <= SIZE_W'(rand_bits(SIZE_W));
        rd_size_o_i   <= SIZE_W'(rand_bits(SIZE_W));
        rd_pcd_i      <= 1'(rand_bits(1));
        sw_valid_e_i  <= 1'(rand_bits(1));
        sw_valid_o_i  <= 1'(rand_bits(1));
        sw_addr_e_i   <= ADDR_W'(rand_bits(ADDR_W));
        sw_addr_o_i   <= ADDR_W'(rand_bits(ADDR_W));
        sw_size_e_i   <= SIZE_W'(rand_bits(SIZE_W));
        sw_size_o_i   <= SIZE_W'(rand_bits(SIZE_W));
        sw_pcd_i      <= 1'(rand_bits(1));
        wb_valid_e_i  <= 1'(rand_bits(1));
        wb_valid_o_i  <= 1'(rand_bits(1));
        wb_addr_e_i   <= ADDR_W'(rand_bits(ADDR_W));
        wb_addr_o_i   <= ADDR_W'(rand_bits(ADDR_W));
        wb_size_e_i   <= SIZE_W'(rand_bits(SIZE_W));
        wb_size_o_i   <= SIZE_W'(rand_bits(SIZE_W));
        wb_pcd_i      <= 1'(rand_bits(1));
        wb_data_e_i   <= DATA_W'(rand_bits(DATA_W));
        wb_data_o_i   <= DATA_W'(rand_bits(DATA_W));
        wb_mask_e_i   <= DATA_W'(rand_bits(DATA_W));
        wb_mask_o_i   <= DATA_W'(rand_bits(DATA_W));
        bus_valid_e_i <= 1'(rand_bits(1));
        bus_valid_o_i <= 1'(rand_bits(1));
        bus_addr_e_i  <= ADDR_W'(rand_bits(ADDR_W));
        bus_addr_o_i  <= ADDR_W'(rand_bits(ADDR_W));
        bus_data_e_i  <= DATA_W'(rand_bits(DATA_W));
        bus_data_o_i  <= DATA_W'(rand_bits(DATA_W));
        bus_pcd_i     <= 1'(rand_bits(1));
    endtask

    task automatic drive_cycle(input logic rd_p, input logic sw_p, input logic wb_p,
                               input logic pop, input logic flush, input logic bus);
        @(posedge clk);
        rd_push_i     <= rd_p;
        sw_push_i     <= sw_p;
        wb_push_i     <= wb_p;
        pop_i         <= pop;
        flush_i       <= flush;
        bus_pending_i <= bus;
        randomize_fields();
    endtask

    task automatic random_cycle();
        logic rd_p, sw_p, wb_p, pop, flush, bus;
        rd_p  = 1'(rand_bits(1));
        sw_p  = 1'(rand_bits(1));
        wb_p  = 1'(rand_bits(1));
        pop   = rand_bits(2) != 32'd0;                 // Pops outpace one queue's pushes
        flush = rand_bits(5) == 32'd0;
        bus   = rand_bits(2) == 32'd0;
        drive_cycle(rd_p, sw_p, wb_p, pop, flush, bus);
    endtask

    initial begin
        lfsr_state    = 16'd5229;
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        pop_i         = 1'b0;
        rd_push_i     = 1'b0;
        sw_push_i     = 1'b0;
        wb_push_i     = 1'b0;
        bus_pending_i = 1'b0;
        randomize_fields();
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < 5; i++) drive_cycle(1, 1, 1, 0, 0, 0);
        for (int i = 0; i < 3; i++) drive_cycle(0, 0, 0, 1, 0, 1);    // Bus holds off the queues
        for (int i = 0; i < 16; i++) drive_cycle(0, 0, 0, 1, 0, 0);   // Drain wb, rd, sw in order
        for (int i = 0; i < DEPTH + 2; i++) drive_cycle(1, 0, 0, 0, 0, 0);
        for (int i = 0; i < DEPTH + 2; i++) drive_cycle(0, 0, 0, 1, 0, 0);
        for (int i = 0; i < 3; i++) drive_cycle(1, 1, 1, 0, 0, 0);
        drive_cycle(1, 1, 0, 0, 1, 0);                                // Flush drops these pushes
        for (int i = 0; i < 6; i++) drive_cycle(0, 0, 0, 1, 0, 0);
        for (int i = 0; i < 3; i++) drive_cycle(0, 0, 0, 1, 0, 1);    // Lone bus entry
        for (int i = 0; i < RAND_CYCLES; i++) random_cycle();
        drive_cycle(0, 0, 0, 0, 0, 0);
        repeat (3) @(posedge clk);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/cache_aq_pkg.sv
source/aq_entry_if.sv
source/aq_fifo.sv
source/aq_arbiter.sv
source/aq_entry_mux.sv
source/cache_aq_top.sv
dv/cache_aq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the access queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f filelist.f --top-module cache_aq_tb -o cache_aq_sim
out=$(./obj_dir/cache_aq_sim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== source/aq_arbiter.sv ====
module aq_arbiter (
    input  logic                           rst_i,
    input  logic                           flush_i,
    input  logic                           pop_i,
    input  logic                           bus_pending_i,
    input  logic                           rd_empty_i,
    input  logic                           sw_empty_i,
    input  logic                           wb_empty_i,
    output logic [cache_aq_pkg::SRC_W-1:0] src_o,
    output logic                           any_o,
    output logic                           rd_pop_o,
    output logic                           sw_pop_o,
    output logic                           wb_pop_o,
    output logic                           rdsw_rst_o
);

    // Fixed priority: bus, writeback, read, store
    always_comb begin
        src_o = cache_aq_pkg::SRC_SW;
        any_o = 1'b1;
        if (bus_pending_i) begin
            src_o = cache_aq_pkg::SRC_BUS;
        end else if (!wb_empty_i) begin
            src_o = cache_aq_pkg::SRC_WB;
        end else if (!rd_empty_i) begin
            src_o = cache_aq_pkg::SRC_RD;
        end else if (!sw_empty_i) begin
            src_o = cache_aq_pkg::SRC_SW;
        end else begin
            any_o = 1'b0;                             // Nothing to present
        end
    end

    // Pop reaches only the selected queue; the bus is popped outside
    assign rd_pop_o = pop_i && any_o && (src_o == cache_aq_pkg::SRC_RD);
    assign sw_pop_o = pop_i && any_o && (src_o == cache_aq_pkg::SRC_SW);
    assign wb_pop_o = pop_i && any_o && (src_o == cache_aq_pkg::SRC_WB);

    // Flush clears read and store queues, writebacks survive
    assign rdsw_rst_o = rst_i || flush_i;

endmodule

// ==== source/aq_entry_if.sv ====
interface aq_entry_if #(
    parameter int DATA_W = 32
);

    logic                            valid_e;
    logic                            valid_o;
    logic [cache_aq_pkg::ADDR_W-1:0] addr_e;
    logic [cache_aq_pkg::ADDR_W-1:0] addr_o;
    logic [cache_aq_pkg::SIZE_W-1:0] size_e;
    logic [cache_aq_pkg::SIZE_W-1:0] size_o;
    logic [DATA_W-1:0]               data_e;
    logic [DATA_W-1:0]               data_o;
    logic [DATA_W-1:0]               mask_e;     // Per-bit write mask
    logic [DATA_W-1:0]               mask_o;
    logic                            pcd;        // Shared by both halves

    modport src (
        output valid_e, valid_o,
        output addr_e, addr_o,
        output size_e, size_o,
        output data_e, data_o,
        output mask_e, mask_o,
        output pcd
    );

    modport snk (
        input valid_e, valid_o,
        input addr_e, addr_o,
        input size_e, size_o,
        input data_e, data_o,
        input mask_e, mask_o,
        input pcd
    );

endinterface

// ==== source/aq_entry_mux.sv ====
module aq_entry_mux #(
    parameter int DATA_W = 32
) (
    input  logic [cache_aq_pkg::SRC_W-1:0]  src_i,
    input  logic                            any_i,
    aq_entry_if.snk                         rd_if,
    aq_entry_if.snk                         sw_if,
    aq_entry_if.snk                         wb_if,
    input  logic                            bus_valid_e_i,
    input  logic                            bus_valid_o_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] bus_addr_e_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] bus_addr_o_i,
    input  logic [DATA_W-1:0]               bus_data_e_i,
    input  logic [DATA_W-1:0]               bus_data_o_i,
    input  logic                            bus_pcd_i,
    aq_entry_if.src                         out_if,
    output logic                            src_rd_o,
    output logic                            src_sw_o,
    output logic                            src_wb_o,
    output logic                            src_bus_o
);

    localparam int ENTRY_W = 3 + 2 * cache_aq_pkg::ADDR_W + 2 * cache_aq_pkg::SIZE_W
                             + 4 * DATA_W;

    logic [ENTRY_W-1:0] rd_word;
    logic [ENTRY_W-1:0] sw_word;
    logic [ENTRY_W-1:0] wb_word;
    logic [ENTRY_W-1:0] bus_word;
    logic [ENTRY_W-1:0] sel_word;
    logic               sel_valid_e;
    logic               sel_valid_o;

    assign rd_word = {rd_if.valid_e, rd_if.valid_o, rd_if.addr_e, rd_if.addr_o,
                      rd_if.size_e, rd_if.size_o, rd_if.data_e, rd_if.data_o,
                      rd_if.mask_e, rd_if.mask_o, rd_if.pcd};
    assign sw_word = {sw_if.valid_e, sw_if.valid_o, sw_if.addr_e, sw_if.addr_o,
                      sw_if.size_e, sw_if.size_o, sw_if.data_e, sw_if.data_o,
                      sw_if.mask_e, sw_if.mask_o, sw_if.pcd};
    assign wb_word = {wb_if.valid_e, wb_if.valid_o, wb_if.addr_e, wb_if.addr_o,
                      wb_if.size_e, wb_if.size_o, wb_if.data_e, wb_if.data_o,
                      wb_if.mask_e, wb_if.mask_o, wb_if.pcd};

    // Fills write whole lines: size zero, all mask bits set
    assign bus_word = {bus_valid_e_i, bus_valid_o_i, bus_addr_e_i, bus_addr_o_i,
                       {2 * cache_aq_pkg::SIZE_W{1'b0}}, bus_data_e_i, bus_data_o_i,
                       {2 * DATA_W{1'b1}}, bus_pcd_i};

    always_comb begin
        case (src_i)
            cache_aq_pkg::SRC_BUS: sel_word = bus_word;
            cache_aq_pkg::SRC_WB:  sel_word = wb_word;
            cache_aq_pkg::SRC_RD:  sel_word = rd_word;
            default:               sel_word = sw_word;
        endcase
    end

    assign {sel_valid_e, sel_valid_o,
            out_if.addr_e, out_if.addr_o,
            out_if.size_e, out_if.size_o,
            out_if.data_e, out_if.data_o,
            out_if.mask_e, out_if.mask_o,
            out_if.pcd} = sel_word;

    assign out_if.valid_e = sel_valid_e && any_i;     // No valid half without work
    assign out_if.valid_o = sel_valid_o && any_i;

    assign src_rd_o  = any_i && (src_i == cache_aq_pkg::SRC_RD);
    assign src_sw_o  = any_i && (src_i == cache_aq_pkg::SRC_SW);
    assign src_wb_o  = any_i && (src_i == cache_aq_pkg::SRC_WB);
    assign src_bus_o = any_i && (src_i == cache_aq_pkg::SRC_BUS);

endmodule

// ==== source/aq_fifo.sv ====
module aq_fifo #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 8
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           push_i,
    input  logic           pop_i,
    aq_entry_if.snk        in_if,
    aq_entry_if.src        head_if,
    output logic           full_o,
    output logic           empty_o
);

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = PTR_W + 1;
    localparam int ENTRY_W = 3 + 2 * cache_aq_pkg::ADDR_W + 2 * cache_aq_pkg::SIZE_W
                             + 4 * DATA_W;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;
    logic [ENTRY_W-1:0] in_word;
    logic [ENTRY_W-1:0] head_word;

    assign in_word = {in_if.valid_e, in_if.valid_o,
                      in_if.addr_e,  in_if.addr_o,
                      in_if.size_e,  in_if.size_o,
                      in_if.data_e,  in_if.data_o,
                      in_if.mask_e,  in_if.mask_o,
                      in_if.pcd};

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);   // Full fifo takes a push only with a pop

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;              // Wraps, DEPTH is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // Fall-through head, zero while empty
    assign head_word = empty_o ? '0 : mem[rd_ptr];

    assign {head_if.valid_e, head_if.valid_o,
            head_if.addr_e,  head_if.addr_o,
            head_if.size_e,  head_if.size_o,
            head_if.data_e,  head_if.data_o,
            head_if.mask_e,  head_if.mask_o,
            head_if.pcd} = head_word;

endmodule

// ==== source/cache_aq_pkg.sv ====
package cache_aq_pkg;

    // Field widths of one half of a request
    localparam int ADDR_W = 15;                // Physical address
    localparam int SIZE_W = 2;                 // Access size code

    // Source codes, shared by the arbiter and the entry mux
    localparam int SRC_W = 2;

    localparam logic [SRC_W-1:0] SRC_RD  = 2'd0;
    localparam logic [SRC_W-1:0] SRC_SW  = 2'd1;
    localparam logic [SRC_W-1:0] SRC_WB  = 2'd2;
    localparam logic [SRC_W-1:0] SRC_BUS = 2'd3;

endpackage

// ==== source/cache_aq_top.sv ====
module cache_aq_top #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 8
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            flush_i,
    input  logic                            pop_i,

    input  logic                            rd_push_i,
    input  logic                            rd_valid_e_i,
    input  logic                            rd_valid_o_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] rd_addr_e_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] rd_addr_o_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] rd_size_e_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] rd_size_o_i,
    input  logic                            rd_pcd_i,

    input  logic                            sw_push_i,
    input  logic                            sw_valid_e_i,
    input  logic                            sw_valid_o_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] sw_addr_e_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] sw_addr_o_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] sw_size_e_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] sw_size_o_i,
    input  logic                            sw_pcd_i,

    input  logic                            wb_push_i,
    input  logic                            wb_valid_e_i,
    input  logic                            wb_valid_o_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] wb_addr_e_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] wb_addr_o_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] wb_size_e_i,
    input  logic [cache_aq_pkg::SIZE_W-1:0] wb_size_o_i,
    input  logic                            wb_pcd_i,
    input  logic [DATA_W-1:0]               wb_data_e_i,
    input  logic [DATA_W-1:0]               wb_data_o_i,
    input  logic [DATA_W-1:0]               wb_mask_e_i,
    input  logic [DATA_W-1:0]               wb_mask_o_i,

    input  logic                            bus_pending_i,
    input  logic                            bus_valid_e_i,
    input  logic                            bus_valid_o_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] bus_addr_e_i,
    input  logic [cache_aq_pkg::ADDR_W-1:0] bus_addr_o_i,
    input  logic [DATA_W-1:0]               bus_data_e_i,
    input  logic [DATA_W-1:0]               bus_data_o_i,
    input  logic                            bus_pcd_i,

    output logic                            valid_e_o,
    output logic                            valid_o_o,
    output logic [cache_aq_pkg::ADDR_W-1:0] addr_e_o,
    output logic [cache_aq_pkg::ADDR_W-1:0] addr_o_o,
    output logic [cache_aq_pkg::SIZE_W-1:0] size_e_o,
    output logic [cache_aq_pkg::SIZE_W-1:0] size_o_o,
    output logic [DATA_W-1:0]               data_e_o,
    output logic [DATA_W-1:0]               data_o_o,
    output logic [DATA_W-1:0]               mask_e_o,
    output logic [DATA_W-1:0]               mask_o_o,
    output logic                            pcd_o,

    output logic                            src_rd_o,
    output logic                            src_sw_o,
    output logic                            src_wb_o,
    output logic                            src_bus_o,

    output logic                            aq_empty_o,
    output logic                            rd_full_o,
    output logic                            sw_full_o,
    output logic                            wb_full_o
);

    aq_entry_if #(.DATA_W(DATA_W)) rd_push ();
    aq_entry_if #(.DATA_W(DATA_W)) sw_push ();
    aq_entry_if #(.DATA_W(DATA_W)) wb_push ();
    aq_entry_if #(.DATA_W(DATA_W)) rd_head ();
    aq_entry_if #(.DATA_W(DATA_W)) sw_head ();
    aq_entry_if #(.DATA_W(DATA_W)) wb_head ();
    aq_entry_if #(.DATA_W(DATA_W)) sel_entry ();

    logic [cache_aq_pkg::SRC_W-1:0] src;
    logic                           any;
    logic                           rd_pop, sw_pop, wb_pop;
    logic                           rd_empty, sw_empty, wb_empty;
    logic                           rdsw_rst;

    // Reads and stores carry no data through the generic queue
    assign rd_push.valid_e = rd_valid_e_i;
    assign rd_push.valid_o = rd_valid_o_i;
    assign rd_push.addr_e  = rd_addr_e_i;
    assign rd_push.addr_o  = rd_addr_o_i;
    assign rd_push.size_e  = rd_size_e_i;
    assign rd_push.size_o  = rd_size_o_i;
    assign rd_push.data_e  = '0;
    assign rd_push.data_o  = '0;
    assign rd_push.mask_e  = '0;
    assign rd_push.mask_o  = '0;
    assign rd_push.pcd     = rd_pcd_i;

    assign sw_push.valid_e = sw_valid_e_i;
    assign sw_push.valid_o = sw_valid_o_i;
    assign sw_push.addr_e  = sw_addr_e_i;
    assign sw_push.addr_o  = sw_addr_o_i;
    assign sw_push.size_e  = sw_size_e_i;
    assign sw_push.size_o  = sw_size_o_i;
    assign sw_push.data_e  = '0;
    assign sw_push.data_o  = '0;
    assign sw_push.mask_e  = '0;
    assign sw_push.mask_o  = '0;
    assign sw_push.pcd     = sw_pcd_i;

    assign wb_push.valid_e = wb_valid_e_i;
    assign wb_push.valid_o = wb_valid_o_i;
    assign wb_push.addr_e  = wb_addr_e_i;
    assign wb_push.addr_o  = wb_addr_o_i;
    assign wb_push.size_e  = wb_size_e_i;
    assign wb_push.size_o  = wb_size_o_i;
    assign wb_push.data_e  = wb_data_e_i;
    assign wb_push.data_o  = wb_data_o_i;
    assign wb_push.mask_e  = wb_mask_e_i;
    assign wb_push.mask_o  = wb_mask_o_i;
    assign wb_push.pcd     = wb_pcd_i;

    aq_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) rd_q (
        .clk(clk), .rst_i(rdsw_rst), .push_i(rd_push_i), .pop_i(rd_pop),
        .in_if(rd_push), .head_if(rd_head), .full_o(rd_full_o), .empty_o(rd_empty)
    );

    aq_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) sw_q (
        .clk(clk), .rst_i(rdsw_rst), .push_i(sw_push_i), .pop_i(sw_pop),
        .in_if(sw_push), .head_if(sw_head), .full_o(sw_full_o), .empty_o(sw_empty)
    );

    aq_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) wb_q (
        .clk(clk), .rst_i(rst_i), .push_i(wb_push_i), .pop_i(wb_pop),
        .in_if(wb_push), .head_if(wb_head), .full_o(wb_full_o), .empty_o(wb_empty)
    );

    aq_arbiter u_arb (
        .rst_i(rst_i), .flush_i(flush_i), .pop_i(pop_i), .bus_pending_i(bus_pending_i),
        .rd_empty_i(rd_empty), .sw_empty_i(sw_empty), .wb_empty_i(wb_empty),
        .src_o(src), .any_o(any),
        .rd_pop_o(rd_pop), .sw_pop_o(sw_pop), .wb_pop_o(wb_pop),
        .rdsw_rst_o(rdsw_rst)
    );

    aq_entry_mux #(.DATA_W(DATA_W)) u_mux (
        .src_i(src), .any_i(any),
        .rd_if(rd_head), .sw_if(sw_head), .wb_if(wb_head),
        .bus_valid_e_i(bus_valid_e_i), .bus_valid_o_i(bus_valid_o_i),
        .bus_addr_e_i(bus_addr_e_i), .bus_addr_o_i(bus_addr_o_i),
        .bus_data_e_i(bus_data_e_i), .bus_data_o_i(bus_data_o_i),
        .bus_pcd_i(bus_pcd_i),
        .out_if(sel_entry),
        .src_rd_o(src_rd_o), .src_sw_o(src_sw_o),
        .src_wb_o(src_wb_o), .src_bus_o(src_bus_o)
    );

    assign valid_e_o = sel_entry.valid_e;
    assign valid_o_o = sel_entry.valid_o;
    assign addr_e_o  = sel_entry.addr_e;
    assign addr_o_o  = sel_entry.addr_o;
    assign size_e_o  = sel_entry.size_e;
    assign size_o_o  = sel_entry.size_o;
    assign data_e_o  = sel_entry.data_e;
    assign data_o_o  = sel_entry.data_o;
    assign mask_e_o  = sel_entry.mask_e;
    assign mask_o_o  = sel_entry.mask_o;
    assign pcd_o     = sel_entry.pcd;

    assign aq_empty_o = !any;

endmodule
